//--- compile.f
hw/irq_pkg.sv
hw/irq_regs.sv
hw/irq_channel.sv
hw/irq_arbiter.sv
hw/irq_ctrl_top.sv
tb/irq_ctrl_chk.sv
tb/irq_ctrl_tb.sv

//--- hw/irq_arbiter.sv
//############################
// fixed priority, index 0 wins; no preemption while a grant is held
// irq_done bits for sources not in service are ignored
//############################
`default_nettype none

module irq_arbiter
    import irq_pkg::*;
#(
    parameter int NUM_IRQ = 8
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               irq_en,     // global enable
    input  wire logic [NUM_IRQ-1:0] pending,
    input  wire logic [NUM_IRQ-1:0] irq_done,   // end of service, per source
    output logic      [NUM_IRQ-1:0] inta,       // one-hot acknowledge, held
    output logic      [NUM_IRQ-1:0] grant,      // pulse on the first inta cycle
    output logic                    main_go     // main thread may run
);

    arb_state_e         state_q;
    arb_state_e         state_nxt;
    logic [NUM_IRQ-1:0] pick;       // lowest pending bit, isolated
    logic               found;      // any pending at all
    logic [NUM_IRQ-1:0] inta_nxt;
    logic [NUM_IRQ-1:0] grant_nxt;

    // priority encoder, first set bit from index 0 up
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (pending[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state_q;
        inta_nxt  = inta;
        grant_nxt = '0;
        case (state_q)
            ARB_IDLE: begin
                if (irq_en && found) begin
                    inta_nxt  = pick;
                    grant_nxt = pick;             // tells the channel to clear its edge
                    state_nxt = ARB_SERVICE;
                end
            end
            ARB_SERVICE: begin
                inta_nxt = inta & ~irq_done;      // pending is not looked at here
                if (inta_nxt == '0) begin
                    state_nxt = ARB_IDLE;         // free to grant from the next edge
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ARB_IDLE;
            inta    <= '0;
            grant   <= '0;
        end else begin
            state_q <= state_nxt;
            inta    <= inta_nxt;
            grant   <= grant_nxt;
        end
    end

    // nothing in service and nothing enabled waiting
    assign main_go = (inta == '0) && !(irq_en && (|pending));

endmodule

`default_nettype wire

//--- hw/irq_channel.sv
//############################
// pin is asynchronous; pending follows it three clocks after it is driven
// polarity change may look like an edge to edge-mode detection
//############################
`default_nettype none

module irq_channel
    import irq_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      pin,       // raw request pin
    input  wire logic      grant,     // one-cycle pulse when this source is acked
    input  wire chan_cfg_t cfg,
    output logic           pending
);

    logic sync1_q;        // first synchronizer stage, may go metastable
    logic sync2_q;        // second stage, safe to use
    logic level;          // polarity-corrected request, 1 = active
    logic level_d_q;      // level one clock earlier
    logic rise;           // inactive to active transition
    logic pending_nxt;

    // two-flop synchronizer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
        end else begin
            sync1_q <= pin;
            sync2_q <= sync1_q;
        end
    end

    // flip active-low pins so 1 always means request
    assign level = sync2_q ^ cfg.active_low;

    // delayed copy for the edge detector
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_d_q <= 1'b0;
        end else begin
            level_d_q <= level;
        end
    end

    assign rise = level & ~level_d_q;

    // Level mode simply tracks the enabled level. Edge mode keeps the flag
    // until the arbiter grants this source; a fresh edge in the grant cycle
    // re-arms it so the second request is not lost.
    always_comb begin
        if (!cfg.enable) begin
            pending_nxt = 1'b0;                  // masked source drops at once
        end else if (!cfg.edge_mode) begin
            pending_nxt = level;
        end else if (rise) begin
            pending_nxt = 1'b1;                  // new edge beats the clear
        end else if (grant) begin
            pending_nxt = 1'b0;
        end else begin
            pending_nxt = pending;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= pending_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hw/irq_ctrl_top.sv
//############################
// NUM_IRQ from 1 to 32; request pins are asynchronous to clk
//############################
`default_nettype none

module irq_ctrl_top
    import irq_pkg::*;
#(
    parameter int NUM_IRQ = 8
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [NUM_IRQ-1:0] irq,        // external request pins
    input  wire logic [NUM_IRQ-1:0] irq_done,   // end of service from the ISR
    input  wire logic               wr,
    input  wire logic               rd,
    input  wire reg_addr_t          addr,
    input  wire reg_data_t          wdata,
    output reg_data_t               rdata,
    output logic                    rvalid,
    output logic      [NUM_IRQ-1:0] inta,       // interrupt acknowledge
    output logic                    main_go
);

    chan_cfg_t [NUM_IRQ-1:0] cfg;         // per-channel mask/mode/polarity
    logic                    irq_en;      // global enable from REG_CTRL
    logic      [NUM_IRQ-1:0] pending;     // one bit from each channel
    logic      [NUM_IRQ-1:0] grant;       // grant pulses back to the channels

    // status words are 32 bits, wider controllers do not fit
    if (NUM_IRQ < 1 || NUM_IRQ > 32) begin : g_bad_num_irq
        $error("irq_ctrl_top: NUM_IRQ must be between 1 and 32");
    end

    irq_regs #(
        .NUM_IRQ (NUM_IRQ)
    ) u_regs (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .pending (pending),
        .inta    (inta),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .cfg     (cfg),
        .irq_en  (irq_en)
    );

    // one identical channel per pin
    for (genvar i = 0; i < NUM_IRQ; i++) begin : g_chan
        irq_channel u_chan (
            .clk     (clk),
            .rst     (rst),
            .pin     (irq[i]),
            .grant   (grant[i]),
            .cfg     (cfg[i]),
            .pending (pending[i])
        );
    end

    irq_arbiter #(
        .NUM_IRQ (NUM_IRQ)
    ) u_arb (
        .clk      (clk),
        .rst      (rst),
        .irq_en   (irq_en),
        .pending  (pending),
        .irq_done (irq_done),
        .inta     (inta),
        .grant    (grant),
        .main_go  (main_go)
    );

endmodule

`default_nettype wire

//--- hw/irq_pkg.sv
//############################
// register data is 32 bits wide, so NUM_IRQ may not exceed 32
// addresses above REG_ACTIVE are unmapped and read as zero
//############################
`default_nettype none

package irq_pkg;

    typedef logic [2:0]  reg_addr_t;      // register address
    typedef logic [31:0] reg_data_t;      // register data word

    // per-source configuration, sliced out of the mask/edge/polarity words
    typedef struct packed {
        logic enable;                     // mask bit, 1 lets the source through
        logic edge_mode;                  // 1 = edge latched, 0 = level
        logic active_low;                 // 1 = pin asserts low
    } chan_cfg_t;

    // arbiter is either free to grant or waiting for end of service
    typedef enum logic [0:0] {
        ARB_IDLE    = 1'b0,
        ARB_SERVICE = 1'b1
    } arb_state_e;

    localparam reg_addr_t REG_MASK     = 3'd0; // per-source enable
    localparam reg_addr_t REG_EDGE     = 3'd1; // per-source edge mode
    localparam reg_addr_t REG_POLARITY = 3'd2; // per-source active low
    localparam reg_addr_t REG_CTRL     = 3'd3; // bit 0 global enable
    localparam reg_addr_t REG_PENDING  = 3'd4; // read only, pending vector
    localparam reg_addr_t REG_ACTIVE   = 3'd5; // read only, inta vector

endpackage

`default_nettype wire

//--- hw/irq_regs.sv
//############################
// plain wr/rd strobes, no wait states; read data lands one clock after rd
// write and read in the same cycle returns the value before the write
//############################
`default_nettype none

module irq_regs
    import irq_pkg::*;
#(
    parameter int NUM_IRQ = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    wr,        // one-cycle write strobe
    input  wire logic                    rd,        // one-cycle read strobe
    input  wire reg_addr_t               addr,
    input  wire reg_data_t               wdata,
    input  wire logic [NUM_IRQ-1:0]      pending,   // live status for readback
    input  wire logic [NUM_IRQ-1:0]      inta,      // live acknowledge for readback
    output reg_data_t                    rdata,
    output logic                         rvalid,
    output chan_cfg_t [NUM_IRQ-1:0]      cfg,       // one config per channel
    output logic                         irq_en     // global enable
);

    logic [NUM_IRQ-1:0] mask_q;     // 1 = source enabled
    logic [NUM_IRQ-1:0] edge_q;     // 1 = edge mode
    logic [NUM_IRQ-1:0] pol_q;      // 1 = active low
    logic               en_q;       // REG_CTRL bit 0
    reg_data_t          rd_mux;     // combinational read select

    // register writes, unmapped addresses fall through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mask_q <= '0;
            edge_q <= '0;
            pol_q  <= '0;
            en_q   <= 1'b0;
        end else if (wr) begin
            case (addr)
                REG_MASK:     mask_q <= wdata[NUM_IRQ-1:0];
                REG_EDGE:     edge_q <= wdata[NUM_IRQ-1:0];
                REG_POLARITY: pol_q  <= wdata[NUM_IRQ-1:0];
                REG_CTRL:     en_q   <= wdata[0];
                default:      ;                            // read only or unmapped
            endcase
        end
    end

    // read select, everything zero-extended to the data word
    always_comb begin
        case (addr)
            REG_MASK:     rd_mux = reg_data_t'(mask_q);
            REG_EDGE:     rd_mux = reg_data_t'(edge_q);
            REG_POLARITY: rd_mux = reg_data_t'(pol_q);
            REG_CTRL:     rd_mux = reg_data_t'(en_q);
            REG_PENDING:  rd_mux = reg_data_t'(pending);
            REG_ACTIVE:   rd_mux = reg_data_t'(inta);
            default:      rd_mux = '0;                     // unmapped reads zero
        endcase
    end

    // registered read port, rdata holds between reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata  <= '0;
            rvalid <= 1'b0;
        end else begin
            rvalid <= rd;                  // one-cycle pulse after rd
            if (rd) begin
                rdata <= rd_mux;           // q values are pre-write here
            end
        end
    end

    // spread the three config words out per channel
    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            cfg[i].enable     = mask_q[i];
            cfg[i].edge_mode  = edge_q[i];
            cfg[i].active_low = pol_q[i];
        end
    end

    assign irq_en = en_q;

endmodule

`default_nettype wire

//--- tb/irq_ctrl_chk.sv
//############################
// bound into irq_arbiter; fail_cnt is read by the testbench at the end
//############################
`default_nettype none

module irq_ctrl_chk #(
    parameter int NUM_IRQ = 8
) (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               irq_en,
    input wire logic [NUM_IRQ-1:0] irq_done,
    input wire logic [NUM_IRQ-1:0] inta,
    input wire logic               main_go
);

    int fail_cnt = 0;       // bumped by every failing assertion

    a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(inta))
        else begin fail_cnt++; $error("inta has more than one bit set"); end

    a_go_low: assert property (@(posedge clk) disable iff (rst) (inta != '0) |-> !main_go)
        else begin fail_cnt++; $error("main_go high while a source is in service"); end

    // nothing new may be acknowledged with the global enable off
    a_no_grant: assert property (@(posedge clk) disable iff (rst)
        !irq_en |=> ((inta & ~$past(inta)) == '0))
        else begin fail_cnt++; $error("inta bit set while irq_en low"); end

    // an acknowledge stays until its own end of service
    for (genvar i = 0; i < NUM_IRQ; i++) begin : g_hold
        a_hold: assert property (@(posedge clk) disable iff (rst)
            (inta[i] && !irq_done[i]) |=> inta[i])
            else begin fail_cnt++; $error("inta bit dropped without irq_done"); end
    end

endmodule

bind irq_arbiter irq_ctrl_chk #(
    .NUM_IRQ (NUM_IRQ)
) u_chk (
    .clk      (clk),
    .rst      (rst),
    .irq_en   (irq_en),
    .irq_done (irq_done),
    .inta     (inta),
    .main_go  (main_go)
);

`default_nettype wire

//--- tb/irq_ctrl_tb.sv
//############################
// NUM_IRQ fixed at 8; model checks inta, main_go, rvalid and rdata every cycle
//############################
`default_nettype none

module irq_ctrl_tb
    import irq_pkg::*;
();

    localparam int NUM_IRQ     = 8;
    localparam int RAND_CYCLES = 2000;   // random part length
    localparam int MAX_CYCLES  = 6000;   // directed part < 400, random 2000, rest is margin

    logic               clk;
    logic               rst;
    logic [NUM_IRQ-1:0] irq;
    logic [NUM_IRQ-1:0] irq_done;
    logic               wr;
    logic               rd;
    reg_addr_t          addr;
    reg_data_t          wdata;
    reg_data_t          rdata;
    logic               rvalid;
    logic [NUM_IRQ-1:0] inta;
    logic               main_go;

    // model state updated at rising edges and compared at falling edges
    logic [NUM_IRQ-1:0] s1_m, s2_m, lvl_d_m, pend_m;
    logic [NUM_IRQ-1:0] mask_m, edge_m, pol_m;
    logic [NUM_IRQ-1:0] inta_m, grant_m;
    logic               en_m, svc_m, exp_rvalid;
    reg_data_t          exp_rdata;
    logic [15:0]        lfsr_q = 16'd94;
    int                 cycles = 0;
    reg_data_t          rv;
    int                 n;

    irq_ctrl_top #(
        .NUM_IRQ (NUM_IRQ)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .irq      (irq),
        .irq_done (irq_done),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .inta     (inta),
        .main_go  (main_go)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // lowest set pending bit wins unless globally disabled
    function automatic logic [NUM_IRQ-1:0] expected_grant(input logic [NUM_IRQ-1:0] pend,
                                                          input logic en);
        return en ? (pend & (~pend + 1'b1)) : '0;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);   // galois with taps 16 14 13 11
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);   // one step per bit taken
            v[i]   = lfsr_q[0];
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vec(input string name, input logic [NUM_IRQ-1:0] got,
                             input logic [NUM_IRQ-1:0] exp);
        if (got !== exp) fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // reference model of channels, registers and arbiter
    always @(posedge clk or posedge rst) begin : p_model
        logic [NUM_IRQ-1:0] lvl, rise, pend_n, inta_n, grant_n;
        logic               svc_n;
        if (rst) begin
            {s1_m, s2_m, lvl_d_m, pend_m} = '0;
            {mask_m, edge_m, pol_m, inta_m, grant_m} = '0;
            {en_m, svc_m, exp_rvalid} = '0;
            exp_rdata = '0;
        end else begin
            lvl  = s2_m ^ pol_m;            // 1 = request active
            rise = lvl & ~lvl_d_m;
            for (int i = 0; i < NUM_IRQ; i++) begin
                if (!mask_m[i])      pend_n[i] = 1'b0;
                else if (!edge_m[i]) pend_n[i] = lvl[i];
                else if (rise[i])    pend_n[i] = 1'b1;   // edge beats the clear
                else if (grant_m[i]) pend_n[i] = 1'b0;
                else                 pend_n[i] = pend_m[i];
            end
            grant_n = '0;
            inta_n  = inta_m;
            svc_n   = svc_m;
            if (!svc_m) begin
                inta_n  = expected_grant(pend_m, en_m);
                grant_n = inta_n;
                svc_n   = (inta_n != '0);
            end else begin
                inta_n = inta_m & ~irq_done;  // pending ignored while in service
                svc_n  = (inta_n != '0);
            end
            exp_rvalid = rd;
            if (rd) begin                     // reads see pre-write values
                case (addr)
                    REG_MASK:     exp_rdata = reg_data_t'(mask_m);
                    REG_EDGE:     exp_rdata = reg_data_t'(edge_m);
                    REG_POLARITY: exp_rdata = reg_data_t'(pol_m);
                    REG_CTRL:     exp_rdata = reg_data_t'(en_m);
                    REG_PENDING:  exp_rdata = reg_data_t'(pend_m);
                    REG_ACTIVE:   exp_rdata = reg_data_t'(inta_m);
                    default:      exp_rdata = '0;
                endcase
            end
            if (wr) begin
                case (addr)
                    REG_MASK:     mask_m = wdata[NUM_IRQ-1:0];
                    REG_EDGE:     edge_m = wdata[NUM_IRQ-1:0];
                    REG_POLARITY: pol_m  = wdata[NUM_IRQ-1:0];
                    REG_CTRL:     en_m   = wdata[0];
                    default:      ;
                endcase
            end
            pend_m  = pend_n;
            lvl_d_m = lvl;
            s2_m    = s1_m;
            s1_m    = irq;
            inta_m  = inta_n;
            grant_m = grant_n;
            svc_m   = svc_n;
        end
    end

    // compare at the falling edge once all outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            if (DUT.u_arb.u_chk.fail_cnt != 0) begin
                fail_run("an assertion on the arbiter outputs failed");
            end
            check_vec("inta", inta, inta_m);
            check_bit("main_go", main_go, (inta_m == '0) && !(en_m && (|pend_m)));
            check_bit("rvalid", rvalid, exp_rvalid);
            check_data("rdata", rdata, exp_rdata);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) fail_run($sformatf("run did not end within %0d cycles",
                                                     MAX_CYCLES));
    end

    task automatic idle(input int k);
        repeat (k) @(posedge clk);
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        @(posedge clk);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_data_t d);
        int w;
        @(posedge clk);
        rd   <= 1'b1;
        addr <= a;
        @(posedge clk);
        rd   <= 1'b0;
        w = 0;
        @(negedge clk);
        while (!rvalid) begin
            w++;
            if (w > 4) fail_run("rvalid never came after a register read");
            @(negedge clk);
        end
        d = rdata;
    endtask

    // counts edges until inta shows exp
    task automatic wait_inta(input logic [NUM_IRQ-1:0] exp, input int limit, output int edges);
        edges = 0;
        forever begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (inta == exp) break;
            if (edges >= limit) fail_run($sformatf("inta never reached 0x%h", exp));
        end
    endtask

    task automatic wait_go(input int limit);
        int k;
        k = 0;
        @(negedge clk);
        while (!main_go) begin
            k++;
            if (k > limit) fail_run("main_go did not return high");
            @(negedge clk);
        end
    endtask

    task automatic done_pulse(input logic [NUM_IRQ-1:0] m);
        @(posedge clk);
        irq_done <= m;
        @(posedge clk);
        irq_done <= '0;
    endtask

    // drop the level pin, let pending fall, then end service
    task automatic service(input int idx);
        @(posedge clk);
        irq[idx] <= 1'b0;
        idle(4);
        done_pulse(NUM_IRQ'(1) << idx);
    endtask

    initial begin
        rst      = 1'b1;
        irq      = '0;
        irq_done = '0;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wdata    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // reset values, readback, unmapped space
        for (int a = 0; a < 8; a++) begin
            read_reg(reg_addr_t'(a), rv);
            check_data("reset readback", rv, '0);
        end
        write_reg(REG_CTRL, 32'h1);
        read_reg(REG_CTRL, rv);
        check_data("REG_CTRL", rv, 32'h1);
        write_reg(REG_CTRL, 32'h0);
        write_reg(REG_MASK, 32'hFFFF_FFA5);
        write_reg(REG_EDGE, 32'h0000_003C);
        write_reg(REG_POLARITY, 32'h0000_000F);
        write_reg(3'd6, 32'h0000_DEAD);
        read_reg(REG_MASK, rv);
        check_data("REG_MASK", rv, 32'h0000_00A5);   // only NUM_IRQ bits kept
        read_reg(REG_EDGE, rv);
        check_data("REG_EDGE", rv, 32'h0000_003C);
        read_reg(REG_POLARITY, rv);
        check_data("REG_POLARITY", rv, 32'h0000_000F);
        read_reg(3'd6, rv);
        check_data("unmapped 6", rv, '0);
        write_reg(REG_MASK, '0);
        write_reg(REG_EDGE, '0);
        write_reg(REG_POLARITY, '0);
        idle(5);

        // single level source with a fixed four-edge latency
        write_reg(REG_MASK, 32'hFF);
        write_reg(REG_CTRL, 32'h1);
        @(posedge clk);
        irq <= 8'h08;
        wait_inta(8'h08, 10, n);
        if (n != 4) fail_run($sformatf("inta came %0d edges after the pin, not 4", n));
        check_bit("main_go", main_go, 1'b0);
        service(3);
        @(negedge clk);
        check_vec("inta", inta, '0);
        wait_go(4);

        // priority order without preemption
        @(posedge clk);
        irq <= 8'h64;
        wait_inta(8'h04, 10, n);
        @(posedge clk);
        irq[0] <= 1'b1;
        idle(6);
        @(negedge clk);
        check_vec("inta", inta, 8'h04);
        service(2);
        wait_inta(8'h01, 6, n);
        service(0);
        wait_inta(8'h20, 6, n);
        service(5);
        wait_inta(8'h40, 6, n);
        service(6);
        wait_go(6);

        // masking and global enable off
        write_reg(REG_CTRL, 32'h0);
        write_reg(REG_MASK, 32'h0F);
        @(posedge clk);
        irq <= 8'hF3;
        idle(5);
        read_reg(REG_PENDING, rv);
        check_data("REG_PENDING", rv, 32'h03);
        read_reg(REG_ACTIVE, rv);
        check_data("REG_ACTIVE", rv, 32'h00);
        check_bit("main_go", main_go, 1'b1);
        @(posedge clk);
        irq <= 8'h80;                       // source 7 idles high for the edge test
        idle(4);

        // active-low edge pulse on source 7
        write_reg(REG_EDGE, 32'h80);
        write_reg(REG_POLARITY, 32'h80);
        write_reg(REG_MASK, 32'hFF);
        write_reg(REG_CTRL, 32'h1);
        @(posedge clk);
        irq <= 8'h00;
        @(posedge clk);
        irq <= 8'h80;
        wait_inta(8'h80, 8, n);
        read_reg(REG_PENDING, rv);
        check_data("REG_PENDING", rv, 32'h00);   // grant cleared the latch
        done_pulse(8'h80);
        @(negedge clk);
        check_vec("inta", inta, '0);

        // random pins, register traffic and end of service
        repeat (RAND_CYCLES) begin
            @(posedge clk);
            irq      <= NUM_IRQ'(rand_bits(NUM_IRQ));
            irq_done <= (rand_bits(2) == 0) ? NUM_IRQ'(rand_bits(NUM_IRQ)) : '0;
            wr       <= (rand_bits(4) == 0);
            rd       <= (rand_bits(2) == 0);
            addr     <= reg_addr_t'(rand_bits(3));
            wdata    <= rand_bits(32);
        end
        @(posedge clk);
        wr  <= 1'b0;
        rd  <= 1'b0;
        irq <= '0;
        idle(8);

        if (DUT.u_arb.u_chk.fail_cnt != 0) begin
            fail_run($sformatf("%0d assertion failures on the arbiter",
                               DUT.u_arb.u_chk.fail_cnt));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
